//--- Makefile
TOP := retimed_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f retimed_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f retimed_core.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- common/rvc_pkg.sv
package rvc_pkg;

	// ##########################################################
	// Vector types.
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] strb_t;
	typedef logic [6:0] opcode_t;

	localparam addr_t reset_pc = 32'h0000_0000;
	localparam int io_delay_stages = 4;
	localparam int num_regs = 32;

	// Major opcodes of the supported subset.
	localparam opcode_t opc_lui = 7'b0110111;
	localparam opcode_t opc_op_imm = 7'b0010011;
	localparam opcode_t opc_op = 7'b0110011;
	localparam opcode_t opc_load = 7'b0000011;
	localparam opcode_t opc_store = 7'b0100011;
	localparam opcode_t opc_branch = 7'b1100011;
	localparam opcode_t opc_jal = 7'b1101111;

	// ##########################################################
	// Enums.
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass
	} alu_op_t;

	typedef enum logic [2:0] {
		class_alu_reg,
		class_alu_imm,
		class_lui,
		class_load,
		class_store,
		class_branch,
		class_jal,
		class_trap
	} op_class_t;

	typedef enum logic [3:0] {
		st_fetch_addr,
		st_fetch_data,
		st_execute,
		st_load_addr,
		st_load_data,
		st_store_addr,
		st_store_resp,
		st_writeback,
		st_halted
	} seq_state_t;

endpackage

//--- core/core_bus_sequencer.sv
`timescale 1ns/1ns

module core_bus_sequencer (
	input  logic               clk,
	input  logic               reset,
	output logic               awvalid,
	input  logic               awready,
	output rvc_pkg::addr_t     awaddr,
	output logic               wvalid,
	input  logic               wready,
	output rvc_pkg::word_t     wdata,
	output rvc_pkg::strb_t     wstrb,
	input  logic               bvalid,
	output logic               bready,
	output logic               arvalid,
	input  logic               arready,
	output rvc_pkg::addr_t     araddr,
	input  logic               rvalid,
	output logic               rready,
	input  rvc_pkg::word_t     rdata,
	output rvc_pkg::word_t     instr,
	output rvc_pkg::addr_t     pc,
	input  rvc_pkg::op_class_t op_class,
	input  rvc_pkg::word_t     result,
	input  rvc_pkg::addr_t     next_pc,
	input  rvc_pkg::addr_t     mem_addr,
	input  rvc_pkg::word_t     src2,
	output logic               we,
	output rvc_pkg::word_t     wd,
	output logic               trap
);
	import rvc_pkg::*;

	seq_state_t state;
	word_t load_data;
	logic aw_fin;
	logic w_fin;

	// A store channel is finished once its valid is low or accepted now.
	assign aw_fin = !awvalid || awready;
	assign w_fin = !wvalid || wready;
	assign wstrb = {$bits(strb_t){wvalid}};

	assign we = (state == st_writeback) &&
		(op_class inside {class_alu_reg, class_alu_imm, class_lui, class_load, class_jal});
	assign wd = (op_class == class_load) ? load_data : result;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_fetch_addr;
			pc <= reset_pc;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			trap <= 1'b0;
		end else begin
			case (state)
			st_fetch_addr, st_load_addr: begin
				if (!arvalid) begin
					arvalid <= 1'b1;
					araddr <= (state == st_fetch_addr) ? pc : mem_addr;
				end else if (arready) begin
					arvalid <= 1'b0;
					rready <= 1'b1;
					state <= (state == st_fetch_addr) ? st_fetch_data : st_load_data;
				end
			end
			st_fetch_data: begin
				if (rvalid) begin
					rready <= 1'b0;
					instr <= rdata;
					state <= st_execute;
				end
			end
			st_execute: begin
				case (op_class)
				class_load: state <= st_load_addr;
				class_store: begin
					awvalid <= 1'b1;
					wvalid <= 1'b1;
					awaddr <= mem_addr;
					wdata <= src2;
					state <= st_store_addr;
				end
				class_trap: begin
					trap <= 1'b1;
					state <= st_halted;
				end
				default: state <= st_writeback;
				endcase
			end
			st_load_data: begin
				if (rvalid) begin
					rready <= 1'b0;
					load_data <= rdata;
					state <= st_writeback;
				end
			end
			st_store_addr: begin
				if (awready) begin
					awvalid <= 1'b0;
				end
				if (wready) begin
					wvalid <= 1'b0;
				end
				if (aw_fin && w_fin) begin
					bready <= 1'b1;
					state <= st_store_resp;
				end
			end
			st_store_resp: begin
				if (bvalid) begin
					bready <= 1'b0;
					state <= st_writeback;
				end
			end
			st_writeback: begin
				pc <= next_pc;
				state <= st_fetch_addr;
			end
			default: state <= st_halted;
			endcase
		end
	end

	// ##########################################################
	// Bus checks.
	property valid_held(logic valid, logic ready);
		@(posedge clk) disable iff (reset) valid && !ready |=> valid;
	endproperty

	assert property (valid_held(arvalid, arready));
	assert property (valid_held(awvalid, awready));
	assert property (valid_held(wvalid, wready));

	// Halt is final until the next reset.
	assert property (@(posedge clk) disable iff (reset) trap |=> trap);
endmodule

//--- core/core_decode.sv
`timescale 1ns/1ns

module core_decode (
	input  rvc_pkg::word_t    instr,
	output rvc_pkg::reg_idx_t rs1,
	output rvc_pkg::reg_idx_t rs2,
	output rvc_pkg::reg_idx_t rd,
	output rvc_pkg::word_t    imm,
	output rvc_pkg::op_class_t op_class,
	output rvc_pkg::alu_op_t  alu_op
);
	import rvc_pkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	always_comb begin
		imm = {{20{instr[31]}}, instr[31:20]};
		op_class = class_trap;
		alu_op = alu_add;
		case (opcode)
		opc_lui: begin
			imm = {instr[31:12], 12'b0};
			op_class = class_lui;
			alu_op = alu_pass;
		end
		opc_op_imm: begin
			op_class = class_alu_imm;
			case (funct3)
			3'b000: alu_op = alu_add;
			3'b100: alu_op = alu_xor;
			3'b110: alu_op = alu_or;
			3'b111: alu_op = alu_and;
			default: op_class = class_trap;
			endcase
		end
		opc_op: begin
			op_class = class_alu_reg;
			case ({funct7, funct3})
			{7'b0000000, 3'b000}: alu_op = alu_add;
			{7'b0100000, 3'b000}: alu_op = alu_sub;
			{7'b0000000, 3'b100}: alu_op = alu_xor;
			{7'b0000000, 3'b110}: alu_op = alu_or;
			{7'b0000000, 3'b111}: alu_op = alu_and;
			default: op_class = class_trap;
			endcase
		end
		opc_load: begin
			if (funct3 == 3'b010) begin
				op_class = class_load;
			end
		end
		opc_store: begin
			imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			if (funct3 == 3'b010) begin
				op_class = class_store;
			end
		end
		opc_branch: begin
			imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			op_class = class_branch;
			// BEQ tests equality through sub. BNE uses xor.
			if (funct3 == 3'b000) begin
				alu_op = alu_sub;
			end else if (funct3 == 3'b001) begin
				alu_op = alu_xor;
			end else begin
				op_class = class_trap;
			end
		end
		opc_jal: begin
			imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			op_class = class_jal;
		end
		default: op_class = class_trap;
		endcase
	end
endmodule

//--- core/core_execute.sv
`timescale 1ns/1ns

module core_execute (
	input  rvc_pkg::op_class_t op_class,
	input  rvc_pkg::alu_op_t   alu_op,
	input  rvc_pkg::word_t     src1,
	input  rvc_pkg::word_t     src2,
	input  rvc_pkg::word_t     imm,
	input  rvc_pkg::addr_t     pc,
	output rvc_pkg::word_t     result,
	output rvc_pkg::addr_t     next_pc,
	output rvc_pkg::addr_t     mem_addr
);
	import rvc_pkg::*;

	word_t operand_b;
	word_t alu_out;
	addr_t pc_plus4;
	addr_t target;
	logic taken;

	assign operand_b = (op_class == class_alu_reg || op_class == class_branch) ? src2 : imm;

	always_comb begin
		case (alu_op)
		alu_add: alu_out = src1 + operand_b;
		alu_sub: alu_out = src1 - operand_b;
		alu_and: alu_out = src1 & operand_b;
		alu_or: alu_out = src1 | operand_b;
		alu_xor: alu_out = src1 ^ operand_b;
		alu_pass: alu_out = operand_b;
		default: alu_out = src1 + operand_b;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign target = pc + imm;

	// Zero result means equal for both sub (BEQ) and xor (BNE).
	assign taken = (op_class == class_branch) && ((alu_out == '0) == (alu_op == alu_sub));

	assign result = (op_class == class_jal) ? pc_plus4 : alu_out;
	assign next_pc = (taken || op_class == class_jal) ? target : pc_plus4;
	assign mem_addr = src1 + imm;
endmodule

//--- core/core_result.sv
`timescale 1ns/1ns

module core_result (
	input  logic              clk,
	input  logic              reset,
	input  rvc_pkg::reg_idx_t rs1,
	input  rvc_pkg::reg_idx_t rs2,
	input  rvc_pkg::reg_idx_t rd,
	input  logic              we,
	input  rvc_pkg::word_t    wd,
	output rvc_pkg::word_t    src1,
	output rvc_pkg::word_t    src2
);
	import rvc_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			// x0 is never written so it keeps its cleared value.
			regs[rd] <= wd;
		end
	end

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];
endmodule

//--- dv/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  grant,
	input  logic        awvalid,
	output logic        awready = 1'b0,
	input  logic [31:0] awaddr,
	input  logic        wvalid,
	output logic        wready = 1'b0,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid = 1'b0,
	input  logic        bready,
	input  logic        arvalid,
	output logic        arready = 1'b0,
	input  logic [31:0] araddr,
	output logic        rvalid = 1'b0,
	input  logic        rready,
	output logic [31:0] rdata = 32'h0,
	output int          writes = 0
);
	logic [31:0] mem [256];
	logic ar_prev, aw_prev, w_prev;
	logic ar_pend, r_pend, aw_pend, w_pend, b_pend;
	logic aw_got, w_got;
	logic [31:0] r_addr, w_addr, w_data;
	logic [3:0] w_strb;

	// Each channel accepts once per rising edge of valid, as seen here.
	always @(posedge clk) begin
		arready <= 1'b0;
		rvalid <= 1'b0;
		awready <= 1'b0;
		wready <= 1'b0;
		bvalid <= 1'b0;
		if (reset) begin
			ar_prev <= 1'b0;
			aw_prev <= 1'b0;
			w_prev <= 1'b0;
			ar_pend <= 1'b0;
			r_pend <= 1'b0;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			b_pend <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			writes <= 0;
		end else begin
			ar_prev <= (arvalid === 1'b1);
			aw_prev <= (awvalid === 1'b1);
			w_prev <= (wvalid === 1'b1);

			// ##########################################################
			// Read path.
			if (arvalid === 1'b1 && !ar_prev) begin
				ar_pend <= 1'b1;
				r_addr <= araddr;
			end else if (ar_pend && grant[0]) begin
				arready <= 1'b1;
				ar_pend <= 1'b0;
				r_pend <= 1'b1;
			end
			if (r_pend && rready === 1'b1 && grant[1]) begin
				rvalid <= 1'b1;
				rdata <= mem[r_addr[9:2]];
				r_pend <= 1'b0;
			end

			// ##########################################################
			// Write path.
			if (awvalid === 1'b1 && !aw_prev) begin
				aw_pend <= 1'b1;
				w_addr <= awaddr;
			end else if (aw_pend && grant[2]) begin
				awready <= 1'b1;
				aw_pend <= 1'b0;
				aw_got <= 1'b1;
			end
			if (wvalid === 1'b1 && !w_prev) begin
				w_pend <= 1'b1;
				w_data <= wdata;
				w_strb <= wstrb;
			end else if (w_pend && grant[3]) begin
				wready <= 1'b1;
				w_pend <= 1'b0;
				w_got <= 1'b1;
			end
			if (aw_got && w_got) begin
				// Only the bytes enabled by the strobe are written.
				for (int b = 0; b < 4; b++) begin
					if (w_strb[b]) begin
						mem[w_addr[9:2]][8*b +: 8] <= w_data[8*b +: 8];
					end
				end
				writes <= writes + 1;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				b_pend <= 1'b1;
			end
			if (b_pend && bready === 1'b1 && grant[4]) begin
				bvalid <= 1'b1;
				b_pend <= 1'b0;
			end
		end
	end
endmodule

//--- dv/retimed_tb.sv
`timescale 1ns/1ns

module retimed_tb;
	import rvc_pkg::*;

	localparam int prog_len = 30;
	localparam int num_exp = 14;
	localparam int timeout_cycles = prog_len * 40 + 16 * io_delay_stages;

	logic clk, reset;
	logic [4:0] grant = 5'b0;
	logic [31:0] lfsr = 32'h5e364137;
	int cycle_count = 0;

	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready, trap;
	addr_t awaddr, araddr;
	word_t wdata, rdata;
	strb_t wstrb;
	int writes;

	word_t prog [prog_len];
	addr_t exp_addr [num_exp];
	word_t exp_data [num_exp];

	tb_clock clock_gen (.clk(clk), .reset(reset));

	retimed_top dut (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.trap(trap)
	);

	axi_mem_model mem_model (
		.clk(clk), .reset(reset), .grant(grant),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.writes(writes)
	);

	// ##########################################################
	// Instruction encoders.
	function automatic word_t rtype(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t itype(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t stype(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t btype(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t jtype(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t fill_word(int idx);
		return 32'hf00d_0000 + word_t'(idx);
	endfunction

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// ##########################################################
	// Checks.
	task automatic check_word(string what, word_t got, word_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal;
		end
	endtask

	task automatic check_trap(logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: trap is %b expected %b", $time, got, exp);
			$display("SOME TESTS FAILED");
			$fatal;
		end
	endtask

	// One LFSR bit per channel per cycle decides whether that channel may accept.
	always @(posedge clk) begin
		logic [31:0] s;
		logic [4:0] bits;
		s = lfsr;
		for (int i = 0; i < 5; i++) begin
			s = lfsr_next(s);
			bits[i] = s[0];
		end
		lfsr <= s;
		grant <= bits;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the core did not reach the halt in %0d cycles", timeout_cycles);
			$display("SOME TESTS FAILED");
			$fatal;
		end
	end

	initial begin
		prog[0] = {20'h12345, 5'd1, 7'b0110111};
		prog[1] = itype(12'h067, 5'd0, 3'b000, 5'd2, 7'b0010011);
		prog[2] = rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		prog[3] = stype(12'h100, 5'd3, 5'd0);
		prog[4] = rtype(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
		prog[5] = stype(12'h104, 5'd4, 5'd0);
		prog[6] = itype(12'hfff, 5'd3, 3'b100, 5'd5, 7'b0010011);
		prog[7] = itype(12'h7f0, 5'd5, 3'b111, 5'd6, 7'b0010011);
		prog[8] = itype(12'h00f, 5'd6, 3'b110, 5'd7, 7'b0010011);
		prog[9] = rtype(7'h00, 5'd7, 5'd3, 3'b100, 5'd8);
		prog[10] = rtype(7'h00, 5'd7, 5'd4, 3'b110, 5'd9);
		prog[11] = rtype(7'h00, 5'd8, 5'd9, 3'b111, 5'd10);
		prog[12] = stype(12'h108, 5'd7, 5'd0);
		prog[13] = stype(12'h10c, 5'd8, 5'd0);
		prog[14] = stype(12'h110, 5'd9, 5'd0);
		prog[15] = stype(12'h114, 5'd10, 5'd0);
		prog[16] = itype(12'h200, 5'd0, 3'b010, 5'd11, 7'b0000011);
		prog[17] = itype(12'h123, 5'd11, 3'b000, 5'd11, 7'b0010011);
		prog[18] = stype(12'h118, 5'd11, 5'd0);
		prog[19] = itype(12'h005, 5'd0, 3'b000, 5'd0, 7'b0010011);
		prog[20] = stype(12'h11c, 5'd0, 5'd0);
		prog[21] = btype(13'd8, 5'd2, 5'd2, 3'b000);
		prog[22] = stype(12'h120, 5'd1, 5'd0);
		prog[23] = btype(13'd8, 5'd2, 5'd2, 3'b001);
		prog[24] = stype(12'h124, 5'd2, 5'd0);
		prog[25] = jtype(21'd8, 5'd12);
		prog[26] = stype(12'h128, 5'd1, 5'd0);
		prog[27] = stype(12'h12c, 5'd12, 5'd0);
		prog[28] = 32'h0010_0073;
		prog[29] = stype(12'h130, 5'd1, 5'd0);

		// Skipped and post-halt stores must leave the fill pattern.
		exp_addr[0] = 32'h100;
		exp_data[0] = 32'h1234_5067;
		exp_addr[1] = 32'h104;
		exp_data[1] = 32'hedcb_b067;
		exp_addr[2] = 32'h108;
		exp_data[2] = 32'h0000_079f;
		exp_addr[3] = 32'h10c;
		exp_data[3] = 32'h1234_57f8;
		exp_addr[4] = 32'h110;
		exp_data[4] = 32'hedcb_b7ff;
		exp_addr[5] = 32'h114;
		exp_data[5] = 32'h0000_17f8;
		exp_addr[6] = 32'h118;
		exp_data[6] = 32'h0bad_f130;
		exp_addr[7] = 32'h11c;
		exp_data[7] = 32'h0000_0000;
		exp_addr[8] = 32'h120;
		exp_data[8] = fill_word(32'h120 >> 2);
		exp_addr[9] = 32'h124;
		exp_data[9] = 32'h0000_0067;
		exp_addr[10] = 32'h128;
		exp_data[10] = fill_word(32'h128 >> 2);
		exp_addr[11] = 32'h12c;
		exp_data[11] = 32'h0000_0068;
		exp_addr[12] = 32'h130;
		exp_data[12] = fill_word(32'h130 >> 2);
		exp_addr[13] = 32'h200;
		exp_data[13] = 32'h0bad_f00d;

		for (int i = 0; i < 256; i++) begin
			mem_model.mem[i] <= fill_word(i);
		end
		for (int i = 0; i < prog_len; i++) begin
			mem_model.mem[i] <= prog[i];
		end
		mem_model.mem[128] <= 32'h0bad_f00d;

		while (trap !== 1'b1) begin
			@(posedge clk);
		end
		repeat (32) @(posedge clk);
		check_trap(trap, 1'b1);
		check_word("write count", word_t'(writes), 32'd10);

		for (int i = 0; i < num_exp; i++) begin
			check_word($sformatf("mem[%h]", exp_addr[i]), mem_model.mem[exp_addr[i][9:2]],
				exp_data[i]);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset is held for eight rising edges.
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end
endmodule

//--- hw/io_delay.sv
`timescale 1ns/1ns

module io_delay #(
	parameter int width = 1
) (
	input  logic             clk,
	input  logic [width-1:0] d,
	output logic [width-1:0] q
);
	import rvc_pkg::*;

	logic [width-1:0] stage [io_delay_stages];

	always_ff @(posedge clk) begin
		stage[0] <= d;
		for (int i = 1; i < io_delay_stages; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	assign q = stage[io_delay_stages-1];
endmodule

//--- hw/retimed_top.sv
`timescale 1ns/1ns

module retimed_top (
	input  logic           clk,
	input  logic           reset,
	output logic           awvalid,
	input  logic           awready,
	output rvc_pkg::addr_t awaddr,
	output logic           wvalid,
	input  logic           wready,
	output rvc_pkg::word_t wdata,
	output rvc_pkg::strb_t wstrb,
	input  logic           bvalid,
	output logic           bready,
	output logic           arvalid,
	input  logic           arready,
	output rvc_pkg::addr_t araddr,
	input  logic           rvalid,
	output logic           rready,
	input  rvc_pkg::word_t rdata,
	output logic           trap
);
	import rvc_pkg::*;

	logic core_reset;
	logic core_awvalid;
	logic core_awready;
	addr_t core_awaddr;
	logic core_wvalid;
	logic core_wready;
	word_t core_wdata;
	strb_t core_wstrb;
	logic core_bvalid;
	logic core_bready;
	logic core_arvalid;
	logic core_arready;
	addr_t core_araddr;
	logic core_rvalid;
	logic core_rready;
	word_t core_rdata;
	logic core_trap;

	word_t instr;
	addr_t pc;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t imm;
	op_class_t op_class;
	alu_op_t alu_op;
	word_t src1;
	word_t src2;
	word_t result;
	addr_t next_pc;
	addr_t mem_addr;
	logic we;
	word_t wd;

	// ##########################################################
	// Retiming on every port, inputs first.
	io_delay #(.width(1)) delay_reset (.clk(clk), .d(reset), .q(core_reset));
	io_delay #(.width(1)) delay_awready (.clk(clk), .d(awready), .q(core_awready));
	io_delay #(.width(1)) delay_wready (.clk(clk), .d(wready), .q(core_wready));
	io_delay #(.width(1)) delay_bvalid (.clk(clk), .d(bvalid), .q(core_bvalid));
	io_delay #(.width(1)) delay_arready (.clk(clk), .d(arready), .q(core_arready));
	io_delay #(.width(1)) delay_rvalid (.clk(clk), .d(rvalid), .q(core_rvalid));
	io_delay #(.width(32)) delay_rdata (.clk(clk), .d(rdata), .q(core_rdata));

	io_delay #(.width(1)) delay_awvalid (.clk(clk), .d(core_awvalid), .q(awvalid));
	io_delay #(.width(32)) delay_awaddr (.clk(clk), .d(core_awaddr), .q(awaddr));
	io_delay #(.width(1)) delay_wvalid (.clk(clk), .d(core_wvalid), .q(wvalid));
	io_delay #(.width(32)) delay_wdata (.clk(clk), .d(core_wdata), .q(wdata));
	io_delay #(.width(4)) delay_wstrb (.clk(clk), .d(core_wstrb), .q(wstrb));
	io_delay #(.width(1)) delay_bready (.clk(clk), .d(core_bready), .q(bready));
	io_delay #(.width(1)) delay_arvalid (.clk(clk), .d(core_arvalid), .q(arvalid));
	io_delay #(.width(32)) delay_araddr (.clk(clk), .d(core_araddr), .q(araddr));
	io_delay #(.width(1)) delay_rready (.clk(clk), .d(core_rready), .q(rready));
	io_delay #(.width(1)) delay_trap (.clk(clk), .d(core_trap), .q(trap));

	// ##########################################################
	// Core.
	core_decode decode (
		.instr   (instr),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.imm     (imm),
		.op_class(op_class),
		.alu_op  (alu_op)
	);

	core_execute execute (
		.op_class(op_class),
		.alu_op  (alu_op),
		.src1    (src1),
		.src2    (src2),
		.imm     (imm),
		.pc      (pc),
		.result  (result),
		.next_pc (next_pc),
		.mem_addr(mem_addr)
	);

	core_result regfile (
		.clk  (clk),
		.reset(core_reset),
		.rs1  (rs1),
		.rs2  (rs2),
		.rd   (rd),
		.we   (we),
		.wd   (wd),
		.src1 (src1),
		.src2 (src2)
	);

	core_bus_sequencer sequencer (
		.clk     (clk),
		.reset   (core_reset),
		.awvalid (core_awvalid),
		.awready (core_awready),
		.awaddr  (core_awaddr),
		.wvalid  (core_wvalid),
		.wready  (core_wready),
		.wdata   (core_wdata),
		.wstrb   (core_wstrb),
		.bvalid  (core_bvalid),
		.bready  (core_bready),
		.arvalid (core_arvalid),
		.arready (core_arready),
		.araddr  (core_araddr),
		.rvalid  (core_rvalid),
		.rready  (core_rready),
		.rdata   (core_rdata),
		.instr   (instr),
		.pc      (pc),
		.op_class(op_class),
		.result  (result),
		.next_pc (next_pc),
		.mem_addr(mem_addr),
		.src2    (src2),
		.we      (we),
		.wd      (wd),
		.trap    (core_trap)
	);
endmodule

//--- retimed_core.f
common/rvc_pkg.sv
hw/io_delay.sv
core/core_decode.sv
core/core_execute.sv
core/core_result.sv
core/core_bus_sequencer.sv
hw/retimed_top.sv
dv/tb_clock.sv
dv/axi_mem_model.sv
dv/retimed_tb.sv
